//--- list.f
verilog/itch_pkg.sv
verilog/quote_if.sv
verilog/order_msg_if.sv
verilog/quote_dispatcher.sv
verilog/order_msg_builder.sv
verilog/msg_serializer.sv
verilog/quote_to_itch_top.sv
verification/tb_quote_to_itch.sv

//--- Makefile
TOP  := tb_quote_to_itch
SRCS := $(filter-out +%,$(shell cat list.f))

.PHONY: all run clean

all: run

obj_dir/V$(TOP): list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'Regression passed'

clean:
	rm -rf obj_dir

//--- verification/tb_quote_to_itch.sv
`timescale 1ns/1ps

module tb_quote_to_itch;
    import itch_pkg::*;

    typedef struct packed {
        order_ref_t oref;
        stock_sym_t sym;
        trade_t     trade;
        price_t     buy;
        price_t     sell;
        qty_t       qty;
        locate_t    loc;
        tracking_t  trk;
        timestamp_t ts;
    } quote_t;

    localparam int          DRAIN_LIMIT = 400;
    localparam int          FIRST_LIMIT = 40;
    localparam logic [7:0]  ADD_CODE    = "A";
    localparam logic [63:0] SYM_TEXT [N_STOCKS] = '{
        "AAPL    ", "AMZN    ", "GOOGL   ", "MSFT    "
    };

    logic       i_clk;
    logic       i_rst_n;
    logic       i_quote_valid;
    stock_sym_t i_stock_symbol;
    trade_t     i_trade_type;
    price_t     i_buy_price;
    price_t     i_sell_price;
    qty_t       i_quantity;
    locate_t    i_locate_code;
    tracking_t  i_tracking_number;
    timestamp_t i_timestamp;
    word_t      o_word;
    logic       o_word_valid;
    logic       o_word_first;
    logic       o_word_last;

    // reference model state
    quote_t              slot [N_STOCKS];
    logic [N_STOCKS-1:0] slot_vld;
    quote_t              pipe1;
    quote_t              pipe2;
    logic                pipe1_vld;
    logic                pipe2_vld;
    int                  busy;
    int                  last_lane;
    int                  cand;
    logic                take_found;
    order_ref_t          model_ref;
    quote_t              exp_q [$];

    // scoreboard state
    quote_t     cur;
    logic       in_pair;
    int         mon_idx;
    word_t      exp_w;
    order_ref_t act_ref;
    int         act_sym;
    order_ref_t seen_refs [$];
    int         seen_syms [$];

    int    errors;
    int    tests_run;
    int    tests_failed;
    int    test_err_base;
    string cur_test;

    quote_to_itch_top dut_i (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_quote_valid     (i_quote_valid),
        .i_stock_symbol    (i_stock_symbol),
        .i_trade_type      (i_trade_type),
        .i_buy_price       (i_buy_price),
        .i_sell_price      (i_sell_price),
        .i_quantity        (i_quantity),
        .i_locate_code     (i_locate_code),
        .i_tracking_number (i_tracking_number),
        .i_timestamp       (i_timestamp),
        .o_word            (o_word),
        .o_word_valid      (o_word_valid),
        .o_word_first      (o_word_first),
        .o_word_last       (o_word_last)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // buy message in words 0..8 and sell message in 9..17
    function automatic word_t exp_word(input quote_t q, input int idx);
        int    w;
        logic  side;
        word_t r;
        w    = idx % MSG_WORDS;
        side = (idx >= MSG_WORDS);
        case (w)
            0:       r = {q.trk[7:0], q.loc, ADD_CODE};
            1:       r = {q.ts[23:0], q.trk[15:8]};
            2:       r = {q.oref[7:0], q.ts[47:24]};
            3:       r = q.oref[39:8];
            4:       r = {7'b0, q.trade, 1'b0, side, q.oref[61:40]};
            5:       r = q.qty;
            6:       r = SYM_TEXT[q.sym][31:0];
            7:       r = SYM_TEXT[q.sym][63:32];
            default: r = side ? q.sell : q.buy;
        endcase
        return r;
    endfunction

    // lane fill two edges after sampling and one take per 18 cycles
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            slot_vld  = '0;
            pipe1_vld = 1'b0;
            pipe2_vld = 1'b0;
            busy      = 0;
            last_lane = N_STOCKS - 1;
            model_ref = '0;
        end else begin
            if (busy > 0) begin
                busy--;
            end else begin
                take_found = 1'b0;
                for (int k = 1; k <= N_STOCKS; k++) begin
                    cand = (last_lane + k) % N_STOCKS;
                    if (!take_found && slot_vld[cand]) begin
                        take_found     = 1'b1;
                        exp_q.push_back(slot[cand]);
                        slot_vld[cand] = 1'b0;
                        last_lane      = cand;
                        busy           = PAIR_WORDS - 1;
                    end
                end
            end
            // a strobe in the take cycle re-arms the lane
            if (pipe2_vld) begin
                slot[pipe2.sym]     = pipe2;
                slot_vld[pipe2.sym] = 1'b1;
            end
            pipe2     = pipe1;
            pipe2_vld = pipe1_vld;
            pipe1_vld = i_quote_valid;
            if (i_quote_valid) begin
                pipe1.oref  = model_ref;
                pipe1.sym   = i_stock_symbol;
                pipe1.trade = i_trade_type;
                pipe1.buy   = i_buy_price;
                pipe1.sell  = i_sell_price;
                pipe1.qty   = i_quantity;
                pipe1.loc   = i_locate_code;
                pipe1.trk   = i_tracking_number;
                pipe1.ts    = i_timestamp;
                model_ref   = model_ref + 62'd1;
            end
        end
    end

    // scoreboard samples outputs on the falling edge
    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            in_pair = 1'b0;
            mon_idx = 0;
        end else if (o_word_valid) begin
            if (o_word_first) begin
                if (in_pair) begin
                    $display("error: test %s, new pair started after %0d words",
                             cur_test, mon_idx);
                    errors++;
                end
                in_pair = 1'b0;
                mon_idx = 0;
                act_sym = -1;
                if (exp_q.size() == 0) begin
                    $display("error: test %s, a pair came out with no quote expected",
                             cur_test);
                    errors++;
                end else begin
                    cur     = exp_q.pop_front();
                    in_pair = 1'b1;
                end
            end else if (!in_pair) begin
                $display("error: test %s, word came out without a first marker", cur_test);
                errors++;
            end
            if (in_pair) begin
                exp_w = exp_word(cur, mon_idx);
                if (o_word !== exp_w) begin
                    $display("mismatch: test %s, word %0d expected %h actual %h",
                             cur_test, mon_idx, exp_w, o_word);
                    errors++;
                end
                if (o_word_last !== (mon_idx == PAIR_WORDS - 1)) begin
                    $display("mismatch: test %s, last marker at word %0d expected %b actual %b",
                             cur_test, mon_idx, (mon_idx == PAIR_WORDS - 1), o_word_last);
                    errors++;
                end
                case (mon_idx)
                    2: act_ref[7:0]   = o_word[31:24];
                    3: act_ref[39:8]  = o_word;
                    4: act_ref[61:40] = o_word[21:0];
                    7: begin
                        for (int s = 0; s < N_STOCKS; s++) begin
                            if (o_word == SYM_TEXT[s][63:32]) begin
                                act_sym = s;
                            end
                        end
                    end
                    default: ;
                endcase
                if (mon_idx == PAIR_WORDS - 1) begin
                    seen_refs.push_back(act_ref);
                    seen_syms.push_back(act_sym);
                    in_pair = 1'b0;
                    mon_idx = 0;
                end else begin
                    mon_idx++;
                end
            end
        end else if (in_pair) begin
            $display("error: test %s, valid dropped after %0d words of a pair",
                     cur_test, mon_idx);
            errors++;
            in_pair = 1'b0;
            mon_idx = 0;
        end
    end

    function automatic stock_sym_t rand_sym();
        return stock_sym_t'($urandom_range(0, N_STOCKS - 1));
    endfunction

    function automatic logic drained();
        return (slot_vld == '0) && !pipe1_vld && !pipe2_vld && (busy == 0) &&
               (exp_q.size() == 0) && !in_pair && !o_word_valid && !i_quote_valid;
    endfunction

    // drives one random quote and leaves valid high
    task automatic drive_quote(input stock_sym_t sym);
        i_quote_valid     = 1'b1;
        i_stock_symbol    = sym;
        i_trade_type      = ($urandom_range(0, 1) != 0) ? TRADE_FLAGGED : TRADE_NORMAL;
        i_buy_price       = $urandom;
        i_sell_price      = $urandom;
        i_quantity        = $urandom;
        i_locate_code     = 16'($urandom);
        i_tracking_number = 16'($urandom);
        i_timestamp       = {16'($urandom), $urandom};
    endtask

    task automatic send_quote(input stock_sym_t sym);
        @(negedge i_clk);
        drive_quote(sym);
        @(negedge i_clk);
        i_quote_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (!drained() && cycles < DRAIN_LIMIT) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!drained()) begin
            $display("error: test %s, timed out waiting for the output to drain", cur_test);
            errors++;
        end
    endtask

    task automatic wait_first(output int lat);
        lat = 0;
        while (!o_word_first && lat < FIRST_LIMIT) begin
            @(negedge i_clk);
            lat++;
        end
        if (!o_word_first) begin
            $display("error: test %s, timed out waiting for a first word", cur_test);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        test_err_base = errors;
        seen_refs.delete();
        seen_syms.delete();
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_err_base) begin
            $display("test %s passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", cur_test, errors - test_err_base);
        end
    endtask

    initial begin
        int         lat;
        int         ref2_hits;
        stock_sym_t sym_a;
        stock_sym_t sym_b;
        order_ref_t ref1;
        order_ref_t ref2;
        order_ref_t want_ref;

        void'($urandom(32'he827_7b88));
        errors            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        cur_test          = "reset";
        i_rst_n           = 1'b0;
        i_quote_valid     = 1'b0;
        i_stock_symbol    = AAPL;
        i_trade_type      = TRADE_NORMAL;
        i_buy_price       = '0;
        i_sell_price      = '0;
        i_quantity        = '0;
        i_locate_code     = '0;
        i_tracking_number = '0;
        i_timestamp       = '0;
        repeat (4) @(negedge i_clk);
        i_rst_n = 1'b1;

        begin_test("reset_idle");
        for (int i = 0; i < 10; i++) begin
            @(negedge i_clk);
            if (o_word_valid || o_word_first || o_word_last) begin
                $display("mismatch: test %s, valid/first/last expected 000 actual %b%b%b",
                         cur_test, o_word_valid, o_word_first, o_word_last);
                errors++;
            end
        end
        end_test();

        begin_test("single_quote");
        send_quote(rand_sym());
        wait_first(lat);
        if (lat != 3) begin
            $display("mismatch: test %s, latency expected 3 actual %0d", cur_test, lat);
            errors++;
        end
        wait_drain();
        if (seen_refs.size() != 1) begin
            $display("mismatch: test %s, pairs expected 1 actual %0d",
                     cur_test, seen_refs.size());
            errors++;
        end else if (seen_refs[0] != '0) begin
            $display("mismatch: test %s, reference expected 0 actual %0d",
                     cur_test, seen_refs[0]);
            errors++;
        end
        end_test();

        // references count up from 1 after the single quote
        begin_test("ref_sequence");
        for (int i = 0; i < 6; i++) begin
            want_ref = order_ref_t'(i + 1);
            send_quote(rand_sym());
            wait_drain();
            if (seen_refs.size() != i + 1) begin
                $display("mismatch: test %s, pairs expected %0d actual %0d",
                         cur_test, i + 1, seen_refs.size());
                errors++;
            end else if (seen_refs[i] != want_ref) begin
                $display("mismatch: test %s, reference expected %0d actual %0d",
                         cur_test, want_ref, seen_refs[i]);
                errors++;
            end
        end
        end_test();

        // arrival order is the reverse of the round-robin order
        begin_test("round_robin");
        sym_a = rand_sym();
        for (int i = 0; i < N_STOCKS; i++) begin
            @(negedge i_clk);
            drive_quote(stock_sym_t'((int'(sym_a) + N_STOCKS - i) % N_STOCKS));
        end
        @(negedge i_clk);
        i_quote_valid = 1'b0;
        wait_drain();
        if (seen_syms.size() != N_STOCKS) begin
            $display("mismatch: test %s, pairs expected 4 actual %0d",
                     cur_test, seen_syms.size());
            errors++;
        end else begin
            for (int i = 0; i < N_STOCKS; i++) begin
                if (seen_syms[i] != (int'(sym_a) + i) % N_STOCKS) begin
                    $display("mismatch: test %s, pair %0d symbol expected %0d actual %0d",
                             cur_test, i, (int'(sym_a) + i) % N_STOCKS, seen_syms[i]);
                    errors++;
                end
            end
        end
        end_test();

        begin_test("overwrite");
        sym_a = rand_sym();
        send_quote(sym_a);
        wait_first(lat);
        sym_b = stock_sym_t'((int'(sym_a) + 1 + $urandom_range(0, 2)) % N_STOCKS);
        ref1  = model_ref;
        send_quote(sym_b);
        ref2  = model_ref;
        send_quote(sym_b);
        wait_drain();
        ref2_hits = 0;
        foreach (seen_refs[i]) begin
            if (seen_refs[i] == ref1) begin
                $display("error: test %s, overwritten reference %0d came out", cur_test, ref1);
                errors++;
            end
            if (seen_refs[i] == ref2) begin
                ref2_hits++;
            end
        end
        if (seen_refs.size() != 2 || ref2_hits != 1) begin
            $display("mismatch: test %s, pairs expected 2 actual %0d, %s %0d",
                     cur_test, seen_refs.size(), "second quote seen expected 1 actual",
                     ref2_hits);
            errors++;
        end
        end_test();

        // dense random traffic with overwrites predicted by the model
        begin_test("random_stream");
        for (int i = 0; i < 200; i++) begin
            repeat ($urandom_range(0, 3)) begin
                @(negedge i_clk);
                i_quote_valid = 1'b0;
            end
            @(negedge i_clk);
            drive_quote(rand_sym());
        end
        @(negedge i_clk);
        i_quote_valid = 1'b0;
        wait_drain();
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- verilog/quote_to_itch_top.sv
`timescale 1ns/1ps

module quote_to_itch_top (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_quote_valid,
    input  itch_pkg::stock_sym_t i_stock_symbol,
    input  itch_pkg::trade_t     i_trade_type,
    input  itch_pkg::price_t     i_buy_price,
    input  itch_pkg::price_t     i_sell_price,
    input  itch_pkg::qty_t       i_quantity,
    input  itch_pkg::locate_t    i_locate_code,
    input  itch_pkg::tracking_t  i_tracking_number,
    input  itch_pkg::timestamp_t i_timestamp,
    output itch_pkg::word_t      o_word,
    output logic                 o_word_valid,
    output logic                 o_word_first,
    output logic                 o_word_last
);
    import itch_pkg::*;

    // one quote bus and one message bus per symbol lane
    quote_if     quote_bus [N_STOCKS] ();
    order_msg_if msg_bus   [N_STOCKS] ();

    quote_dispatcher dispatcher_i (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_quote_valid     (i_quote_valid),
        .i_stock_symbol    (i_stock_symbol),
        .i_trade_type      (i_trade_type),
        .i_buy_price       (i_buy_price),
        .i_sell_price      (i_sell_price),
        .i_quantity        (i_quantity),
        .i_locate_code     (i_locate_code),
        .i_tracking_number (i_tracking_number),
        .i_timestamp       (i_timestamp),
        .q_if              (quote_bus)
    );

    for (genvar g = 0; g < N_STOCKS; g++) begin : g_lane
        order_msg_builder #(
            .LANE (g)
        ) builder_i (
            .i_clk   (i_clk),
            .i_rst_n (i_rst_n),
            .q_if    (quote_bus[g]),
            .m_if    (msg_bus[g])
        );
    end

    msg_serializer serializer_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .m_if         (msg_bus),
        .o_word       (o_word),
        .o_word_valid (o_word_valid),
        .o_word_first (o_word_first),
        .o_word_last  (o_word_last)
    );

endmodule

//--- verilog/msg_serializer.sv
`timescale 1ns/1ps

module msg_serializer (
    input  logic            i_clk,
    input  logic            i_rst_n,
    order_msg_if.drain      m_if [itch_pkg::N_STOCKS],
    output itch_pkg::word_t o_word,
    output logic            o_word_valid,
    output logic            o_word_first,
    output logic            o_word_last
);
    import itch_pkg::*;

    ser_state_t             state;
    word_idx_t              word_idx;
    lane_idx_t              last_lane;
    lane_idx_t              grant_idx;
    logic                   grant_found;
    logic [N_STOCKS-1:0]    pend_vec;
    logic [N_STOCKS-1:0]    take_vec;
    word_t [PAIR_WORDS-1:0] lane_words [N_STOCKS];
    word_t [PAIR_WORDS-1:0] pair_q;

    for (genvar g = 0; g < N_STOCKS; g++) begin : g_lane
        assign pend_vec[g]   = m_if[g].pending;
        assign lane_words[g] = m_if[g].words;
        assign m_if[g].take  = take_vec[g];
    end

    // round robin, search starts at the lane after the last served
    always_comb begin
        lane_idx_t cand;
        grant_found = 1'b0;
        grant_idx   = last_lane;
        for (int k = 1; k <= N_STOCKS; k++) begin
            cand = lane_idx_t'((int'(last_lane) + k) % N_STOCKS);
            if (!grant_found && pend_vec[cand]) begin
                grant_found = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    always_comb begin
        take_vec = '0;
        if (state == SER_IDLE && grant_found) begin
            take_vec[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state        <= SER_IDLE;
            word_idx     <= '0;
            last_lane    <= lane_idx_t'(N_STOCKS - 1);
            o_word_valid <= 1'b0;
            o_word_first <= 1'b0;
            o_word_last  <= 1'b0;
        end else begin
            case (state)
                SER_IDLE: begin
                    o_word_last  <= 1'b0;
                    o_word_valid <= grant_found;
                    o_word_first <= grant_found;
                    if (grant_found) begin
                        // word 0 goes out straight from the lane
                        word_idx  <= word_idx_t'(1);
                        last_lane <= grant_idx;
                        state     <= SER_SEND;
                    end
                end
                SER_SEND: begin
                    o_word_valid <= 1'b1;
                    o_word_first <= 1'b0;
                    o_word_last  <= (word_idx == word_idx_t'(PAIR_WORDS - 1));
                    if (word_idx == word_idx_t'(PAIR_WORDS - 1)) begin
                        state <= SER_IDLE;
                    end else begin
                        word_idx <= word_idx + 1'b1;
                    end
                end
                default: state <= SER_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == SER_IDLE) begin
            if (grant_found) begin
                pair_q <= lane_words[grant_idx];
                o_word <= lane_words[grant_idx][0];
            end
        end else begin
            o_word <= pair_q[word_idx];
        end
    end

    a_markers_valid: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_word_first || o_word_last) |-> o_word_valid
    );

    a_single_take: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) $onehot0(take_vec)
    );

endmodule

//--- verilog/order_msg_builder.sv
`timescale 1ns/1ps

module order_msg_builder #(
    parameter int LANE = 0
) (
    input  logic      i_clk,
    input  logic      i_rst_n,
    quote_if.sink     q_if,
    order_msg_if.lane m_if
);
    import itch_pkg::*;

    word_t [PAIR_WORDS-1:0] next_words;

    // buy message first, then sell; only words 4 and 8 differ
    always_comb begin
        side_t side;
        int    base;
        next_words = '0;
        for (int s = 0; s < 2; s++) begin
            side = side_t'(s);
            base = s * MSG_WORDS;

            // tracking low byte, locate, message type
            next_words[base + 0] = {q_if.tracking[7:0], q_if.locate, MSG_TYPE_ADD};
            next_words[base + 1] = {q_if.timestamp[23:0], q_if.tracking[15:8]};
            next_words[base + 2] = {q_if.order_ref[7:0], q_if.timestamp[47:24]};
            next_words[base + 3] = q_if.order_ref[39:8];

            // flags byte, then top 22 bits of the reference
            next_words[base + 4] = {
                7'b0,
                q_if.trade_type,
                1'b0,
                side,
                q_if.order_ref[61:40]
            };

            next_words[base + 5] = q_if.quantity;
            next_words[base + 6] = SYMBOL_ASCII[LANE][31:0];
            next_words[base + 7] = SYMBOL_ASCII[LANE][63:32];
            next_words[base + 8] = (side == BUY) ? q_if.buy_price : q_if.sell_price;
        end
    end

    // a newer quote simply overwrites the held pair
    always_ff @(posedge i_clk) begin
        if (q_if.strobe) begin
            m_if.words <= next_words;
        end
    end

    // strobe wins over take so a quote at the boundary is kept
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            m_if.pending <= 1'b0;
        end else if (q_if.strobe) begin
            m_if.pending <= 1'b1;
        end else if (m_if.take) begin
            m_if.pending <= 1'b0;
        end
    end

    a_take_when_pending: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) m_if.take |-> m_if.pending
    );

endmodule

//--- verilog/quote_dispatcher.sv
`timescale 1ns/1ps

module quote_dispatcher (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_quote_valid,
    input  itch_pkg::stock_sym_t i_stock_symbol,
    input  itch_pkg::trade_t     i_trade_type,
    input  itch_pkg::price_t     i_buy_price,
    input  itch_pkg::price_t     i_sell_price,
    input  itch_pkg::qty_t       i_quantity,
    input  itch_pkg::locate_t    i_locate_code,
    input  itch_pkg::tracking_t  i_tracking_number,
    input  itch_pkg::timestamp_t i_timestamp,
    quote_if.source              q_if [itch_pkg::N_STOCKS]
);
    import itch_pkg::*;

    order_ref_t            ref_cnt;
    logic                  vld_q;
    stock_sym_t            sym_q;
    order_ref_t            ref_q;
    trade_t                trade_q;
    price_t                buy_q;
    price_t                sell_q;
    qty_t                  qty_q;
    locate_t               locate_q;
    tracking_t             tracking_q;
    timestamp_t            ts_q;
    logic [N_STOCKS-1:0]   strobe_q;
    order_ref_t            ref_d2;
    trade_t                trade_d2;
    price_t                buy_d2;
    price_t                sell_d2;
    qty_t                  qty_d2;
    locate_t               locate_d2;
    tracking_t             tracking_d2;
    timestamp_t            ts_d2;

    // stage 1, capture and number the quote
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            vld_q   <= 1'b0;
            ref_cnt <= '0;
        end else begin
            vld_q <= i_quote_valid;
            if (i_quote_valid) begin
                ref_cnt <= ref_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_quote_valid) begin
            sym_q      <= i_stock_symbol;
            ref_q      <= ref_cnt;
            trade_q    <= i_trade_type;
            buy_q      <= i_buy_price;
            sell_q     <= i_sell_price;
            qty_q      <= i_quantity;
            locate_q   <= i_locate_code;
            tracking_q <= i_tracking_number;
            ts_q       <= i_timestamp;
        end
    end

    // stage 2, one-hot lane strobe from the symbol
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            strobe_q <= '0;
        end else begin
            strobe_q <= vld_q ? (N_STOCKS'(1) << sym_q) : '0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (vld_q) begin
            ref_d2      <= ref_q;
            trade_d2    <= trade_q;
            buy_d2      <= buy_q;
            sell_d2     <= sell_q;
            qty_d2      <= qty_q;
            locate_d2   <= locate_q;
            tracking_d2 <= tracking_q;
            ts_d2       <= ts_q;
        end
    end

    // fields are shared, only the strobe is per lane
    for (genvar g = 0; g < N_STOCKS; g++) begin : g_lane
        assign q_if[g].strobe     = strobe_q[g];
        assign q_if[g].order_ref  = ref_d2;
        assign q_if[g].trade_type = trade_d2;
        assign q_if[g].buy_price  = buy_d2;
        assign q_if[g].sell_price = sell_d2;
        assign q_if[g].quantity   = qty_d2;
        assign q_if[g].locate     = locate_d2;
        assign q_if[g].tracking   = tracking_d2;
        assign q_if[g].timestamp  = ts_d2;
    end

    a_one_lane_strobe: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) $onehot0(strobe_q)
    );

endmodule

//--- verilog/order_msg_if.sv
`timescale 1ns/1ps

interface order_msg_if;
    import itch_pkg::*;

    // buy message in words 0..8, sell message in words 9..17
    word_t [PAIR_WORDS-1:0] words;
    logic                   pending;
    logic                   take;

    modport lane (
        output words,
        output pending,
        input  take
    );

    // take is a single cycle pulse, only while pending
    modport drain (
        input  words,
        input  pending,
        output take
    );

endinterface

//--- verilog/quote_if.sv
`timescale 1ns/1ps

interface quote_if;
    import itch_pkg::*;

    logic       strobe;
    order_ref_t order_ref;
    trade_t     trade_type;
    price_t     buy_price;
    price_t     sell_price;
    qty_t       quantity;
    locate_t    locate;
    tracking_t  tracking;
    timestamp_t timestamp;

    // dispatcher side
    modport source (
        output strobe, order_ref, trade_type, buy_price, sell_price,
        output quantity, locate, tracking, timestamp
    );

    // lane side, fields only valid while strobe is high
    modport sink (
        input strobe, order_ref, trade_type, buy_price, sell_price,
        input quantity, locate, tracking, timestamp
    );

endinterface

//--- verilog/itch_pkg.sv
package itch_pkg;

    localparam int N_STOCKS    = 4;
    localparam int WORD_W      = 32;
    localparam int MSG_WORDS   = 9;
    localparam int PAIR_WORDS  = 2 * MSG_WORDS;
    localparam int ORDER_REF_W = 62;
    localparam int TIMESTAMP_W = 48;

    typedef logic [WORD_W-1:0]              word_t;
    typedef logic [31:0]                    price_t;
    typedef logic [31:0]                    qty_t;
    typedef logic [15:0]                    locate_t;
    typedef logic [15:0]                    tracking_t;
    typedef logic [TIMESTAMP_W-1:0]         timestamp_t;
    typedef logic [ORDER_REF_W-1:0]         order_ref_t;
    typedef logic [$clog2(N_STOCKS)-1:0]    lane_idx_t;
    typedef logic [$clog2(PAIR_WORDS)-1:0]  word_idx_t;

    typedef enum logic [1:0] {
        AAPL  = 2'd0,
        AMZN  = 2'd1,
        GOOGL = 2'd2,
        MSFT  = 2'd3
    } stock_sym_t;

    // side bit of word 4
    typedef enum logic {
        BUY  = 1'b0,
        SELL = 1'b1
    } side_t;

    typedef enum logic {
        TRADE_NORMAL  = 1'b0,
        TRADE_FLAGGED = 1'b1
    } trade_t;

    typedef enum logic {
        SER_IDLE = 1'b0,
        SER_SEND = 1'b1
    } ser_state_t;

    // ascii 'A'
    localparam logic [7:0] MSG_TYPE_ADD = 8'h41;

    // first character in the top byte, space padded
    localparam logic [63:0] SYMBOL_ASCII [N_STOCKS] = '{
        64'h4141_504c_2020_2020,
        64'h414d_5a4e_2020_2020,
        64'h474f_4f47_4c20_2020,
        64'h4d53_4654_2020_2020
    };

endpackage
